// ==== Bender.yml ====
package:
  name: dcache_bank

sources:
  # design, in compile order
  - source/dcache_pkg.sv
  - source/priority_encoder.sv
  - source/way_store.sv
  - source/set_ways.sv
  - source/miss_controller.sv
  - source/dcache_bank.sv

  # verification
  - target: simulation
    files:
      - verif/dcache_assertions.sv
      - verif/dcache_tb.sv

// ==== build.f ====
source/dcache_pkg.sv
source/priority_encoder.sv
source/way_store.sv
source/set_ways.sv
source/miss_controller.sv
source/dcache_bank.sv
verif/dcache_assertions.sv
verif/dcache_tb.sv

// ==== source/dcache_bank.sv ====
`timescale 1ns/1ps

module dcache_bank (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  dcache_pkg::cache_req_t req,
    output logic                   rsp_valid,
    output dcache_pkg::cache_rsp_t rsp,
    output logic                   busy,
    output logic                   mem_wb_valid,
    output dcache_pkg::mem_line_t  mem_wb,
    output logic                   mem_rd_valid,
    output dcache_pkg::index_t     mem_rd_index,
    output dcache_pkg::tag_t       mem_rd_tag,
    input  logic                   mem_fill_valid,
    input  dcache_pkg::block_t     mem_fill_data
);

    // controller to ways
    dcache_pkg::set_cmd_t cmd;

    // selected way back to the controller
    dcache_pkg::tag_t   tag_use;
    dcache_pkg::block_t data_use;
    logic               valid_use;
    logic               dirty_use;
    logic               hit;
    logic               invalid_found;
    dcache_pkg::way_t   invalid_way;

    miss_controller miss_controller_i (
        .clk, .rst_n, .req_valid, .req, .hit, .tag_use, .data_use, .valid_use,
        .dirty_use, .invalid_found, .invalid_way, .cmd, .busy, .rsp_valid, .rsp,
        .mem_wb_valid, .mem_wb, .mem_rd_valid, .mem_rd_index, .mem_rd_tag,
        .mem_fill_valid, .mem_fill_data
    );

    set_ways set_ways_i (
        .clk, .rst_n, .cmd, .tag_use, .data_use, .valid_use, .dirty_use,
        .hit, .invalid_found, .invalid_way
    );

endmodule

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    // bank geometry
    localparam int num_ways        = 2;
    localparam int num_sets        = 8;
    localparam int words_per_block = 4;

    // derived widths
    localparam int word_width    = 32;
    localparam int block_width   = words_per_block * word_width;
    localparam int byte_en_width = block_width / 8;
    localparam int index_width   = $clog2(num_sets);
    localparam int tag_width     = 8;
    localparam int way_width     = $clog2(num_ways);

    typedef logic [index_width-1:0]   index_t;
    typedef logic [tag_width-1:0]     tag_t;
    typedef logic [way_width-1:0]     way_t;
    typedef logic [byte_en_width-1:0] byte_en_t;
    typedef logic [block_width-1:0]   block_t;

    // one access from the requester
    typedef struct packed {
        index_t   index;
        tag_t     tag;
        byte_en_t byte_en;
        block_t   wdata;
    } cache_req_t;

    // data is the block before this request's own write
    typedef struct packed {
        logic   hit;
        block_t data;
    } cache_rsp_t;

    // write-back and fill line
    typedef struct packed {
        index_t index;
        tag_t   tag;
        block_t data;
    } mem_line_t;

    // controller to set_ways
    typedef struct packed {
        index_t   index;
        tag_t     tag;
        logic     use_victim;
        way_t     victim_way;
        byte_en_t byte_en;
        block_t   wdata;
        logic     fill;
    } set_cmd_t;

    typedef enum logic [1:0] {st_idle, st_write_back, st_read_req, st_wait_fill} miss_state_t;

endpackage

// ==== source/miss_controller.sv ====
`timescale 1ns/1ps

module miss_controller (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  dcache_pkg::cache_req_t req,
    input  logic                   hit,
    input  dcache_pkg::tag_t       tag_use,
    input  dcache_pkg::block_t     data_use,
    input  logic                   valid_use,
    input  logic                   dirty_use,
    input  logic                   invalid_found,
    input  dcache_pkg::way_t       invalid_way,
    output dcache_pkg::set_cmd_t   cmd,
    output logic                   busy,
    output logic                   rsp_valid,
    output dcache_pkg::cache_rsp_t rsp,
    output logic                   mem_wb_valid,
    output dcache_pkg::mem_line_t  mem_wb,
    output logic                   mem_rd_valid,
    output dcache_pkg::index_t     mem_rd_index,
    output dcache_pkg::tag_t       mem_rd_tag,
    input  logic                   mem_fill_valid,
    input  dcache_pkg::block_t     mem_fill_data
);

    dcache_pkg::miss_state_t state_q;
    dcache_pkg::cache_req_t  req_q;
    dcache_pkg::way_t        victim_q;
    dcache_pkg::way_t        rr_q;
    dcache_pkg::block_t      merged;
    logic                    idle;
    logic                    miss;
    logic                    fill_now;

    assign idle     = (state_q == dcache_pkg::st_idle);
    assign miss     = idle && req_valid && !hit;
    assign fill_now = (state_q == dcache_pkg::st_wait_fill) && mem_fill_valid;
    assign busy     = !idle;

    // request bytes win over fill bytes
    always_comb begin
        merged = mem_fill_data;
        for (int b = 0; b < dcache_pkg::byte_en_width; b++) begin
            if (req_q.byte_en[b]) merged[b*8 +: 8] = req_q.wdata[b*8 +: 8];
        end
    end

    // idle passes the live request, otherwise the latched one on the victim
    assign cmd.index      = idle ? req.index : req_q.index;
    assign cmd.tag        = idle ? req.tag : req_q.tag;
    assign cmd.use_victim = !idle;
    assign cmd.victim_way = victim_q;
    assign cmd.byte_en    = (idle && req_valid && hit) ? req.byte_en :
                            fill_now ? req_q.byte_en : '0;
    assign cmd.wdata      = idle ? req.wdata : merged;
    assign cmd.fill       = fill_now;

    // hit answers now, miss answers with the raw fill
    assign rsp_valid = (idle && req_valid && hit) || fill_now;
    assign rsp.hit   = idle;
    assign rsp.data  = idle ? data_use : mem_fill_data;

    // victim contents come straight from the selected way
    assign mem_wb_valid = (state_q == dcache_pkg::st_write_back) && valid_use && dirty_use;
    assign mem_wb.index = req_q.index;
    assign mem_wb.tag   = tag_use;
    assign mem_wb.data  = data_use;

    assign mem_rd_valid = (state_q == dcache_pkg::st_read_req);
    assign mem_rd_index = req_q.index;
    assign mem_rd_tag   = req_q.tag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= dcache_pkg::st_idle;
            rr_q    <= '0;
        end else begin
            case (state_q)
                dcache_pkg::st_idle: begin
                    if (miss) state_q <= dcache_pkg::st_write_back;
                    // round robin moves only when every way is taken
                    if (miss && !invalid_found) begin
                        if (rr_q == dcache_pkg::way_t'(dcache_pkg::num_ways - 1)) rr_q <= '0;
                        else rr_q <= rr_q + 1'b1;
                    end
                end
                dcache_pkg::st_write_back: state_q <= dcache_pkg::st_read_req;
                dcache_pkg::st_read_req:   state_q <= dcache_pkg::st_wait_fill;
                dcache_pkg::st_wait_fill: begin
                    if (mem_fill_valid) state_q <= dcache_pkg::st_idle;
                end
                default: state_q <= dcache_pkg::st_idle;
            endcase
        end
    end

    // latched miss and its victim
    always_ff @(posedge clk) begin
        if (miss) begin
            req_q    <= req;
            victim_q <= invalid_found ? invalid_way : rr_q;
        end
    end

endmodule

// ==== source/priority_encoder.sv ====
`timescale 1ns/1ps

module priority_encoder #(
    parameter int n = 2
) (
    input  logic [n-1:0]         valids,
    output logic [$clog2(n)-1:0] index,
    output logic                 found
);

    // scan from the top so the lowest set bit is written last
    always_comb begin
        index = '0;
        found = 1'b0;
        for (int i = n - 1; i >= 0; i--) begin
            if (valids[i]) begin
                index = i[$clog2(n)-1:0];
                found = 1'b1;
            end
        end
    end

endmodule

// ==== source/set_ways.sv ====
`timescale 1ns/1ps

module set_ways (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dcache_pkg::set_cmd_t cmd,
    output dcache_pkg::tag_t     tag_use,
    output dcache_pkg::block_t   data_use,
    output logic                 valid_use,
    output logic                 dirty_use,
    output logic                 hit,
    output logic                 invalid_found,
    output dcache_pkg::way_t     invalid_way
);

    // per-way views of the addressed set
    dcache_pkg::tag_t   tag_per_way  [dcache_pkg::num_ways];
    dcache_pkg::block_t data_per_way [dcache_pkg::num_ways];
    logic [dcache_pkg::num_ways-1:0] valid_per_way;
    logic [dcache_pkg::num_ways-1:0] dirty_per_way;
    logic [dcache_pkg::num_ways-1:0] hit_per_way;

    dcache_pkg::way_t hit_way;
    dcache_pkg::way_t way_sel;

    // lowest hitting way
    priority_encoder #(.n(dcache_pkg::num_ways)) hit_enc_i (
        .valids(hit_per_way),
        .index (hit_way),
        .found (hit)
    );

    // lowest empty way, first choice for a victim
    priority_encoder #(.n(dcache_pkg::num_ways)) invalid_enc_i (
        .valids(~valid_per_way),
        .index (invalid_way),
        .found (invalid_found)
    );

    // controller owns the way while a miss is in flight
    assign way_sel = cmd.use_victim ? cmd.victim_way : hit_way;

    assign tag_use   = tag_per_way[way_sel];
    assign data_use  = data_per_way[way_sel];
    assign valid_use = valid_per_way[way_sel];
    assign dirty_use = dirty_per_way[way_sel];

    for (genvar w = 0; w < dcache_pkg::num_ways; w++) begin : g_way
        dcache_pkg::byte_en_t way_byte_en;
        logic                 way_fill;

        assign hit_per_way[w] = valid_per_way[w] && (tag_per_way[w] == cmd.tag);

        // writes reach only the selected way
        assign way_byte_en = (way_sel == w) ? cmd.byte_en : '0;
        assign way_fill    = cmd.fill && (way_sel == w);

        way_store way_store_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .index    (cmd.index),
            .byte_en  (way_byte_en),
            .fill     (way_fill),
            .wdata    (cmd.wdata),
            .tag_write(cmd.tag),
            .tag_use  (tag_per_way[w]),
            .data_use (data_per_way[w]),
            .valid_use(valid_per_way[w]),
            .dirty_use(dirty_per_way[w])
        );
    end

endmodule

// ==== source/way_store.sv ====
`timescale 1ns/1ps

module way_store (
    input  logic                clk,
    input  logic                rst_n,
    input  dcache_pkg::index_t   index,
    input  dcache_pkg::byte_en_t byte_en,
    input  logic                fill,
    input  dcache_pkg::block_t   wdata,
    input  dcache_pkg::tag_t     tag_write,
    output dcache_pkg::tag_t     tag_use,
    output dcache_pkg::block_t   data_use,
    output logic                valid_use,
    output logic                dirty_use
);

    // per-set storage of this way
    dcache_pkg::tag_t   tag_mem  [dcache_pkg::num_sets];
    dcache_pkg::block_t data_mem [dcache_pkg::num_sets];
    logic [dcache_pkg::num_sets-1:0] valid_q;
    logic [dcache_pkg::num_sets-1:0] dirty_q;

    logic any_byte;

    assign any_byte = |byte_en;

    // asynchronous read at the current set
    assign tag_use   = tag_mem[index];
    assign data_use  = data_mem[index];
    assign valid_use = valid_q[index];
    assign dirty_use = dirty_q[index];

    // status bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill) begin
            valid_q[index] <= 1'b1;
            // dirty only when the missing request wrote bytes
            dirty_q[index] <= any_byte;
        end else if (any_byte) begin
            dirty_q[index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[index]  <= tag_write;
            data_mem[index] <= wdata;
        end else begin
            // byte-granular update of a resident block
            for (int b = 0; b < dcache_pkg::byte_en_width; b++) begin
                if (byte_en[b]) begin
                    data_mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== verif/dcache_assertions.sv ====
`timescale 1ns/1ps

module dcache_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    req_valid,
    input logic                    busy,
    input logic                    rsp_valid,
    input logic                    mem_wb_valid,
    input logic                    mem_rd_valid,
    input logic                    mem_fill_valid,
    input dcache_pkg::miss_state_t state
);

    // failures seen by the testbench at the end of the run
    int fail_count = 0;

    // requester holds off while a miss is in flight
    req_while_idle: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> !busy)
        else begin
            fail_count++;
            $error("request issued while the bank was busy");
        end

    // fill only answers an issued read
    fill_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
        mem_fill_valid |-> state == dcache_pkg::st_wait_fill)
        else begin
            fail_count++;
            $error("fill arrived outside the wait state");
        end

    wb_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wb_valid |=> !mem_wb_valid)
        else begin
            fail_count++;
            $error("write-back strobe held for more than one cycle");
        end

    rd_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd_valid |=> !mem_rd_valid)
        else begin
            fail_count++;
            $error("read strobe held for more than one cycle");
        end

    // no answer while the missing block is only being requested
    no_rsp_with_rd: assert property (@(posedge clk) disable iff (!rst_n)
        !(rsp_valid && mem_rd_valid))
        else begin
            fail_count++;
            $error("response and read request in the same cycle");
        end

endmodule

bind dcache_bank dcache_assertions dcache_assertions_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .busy          (busy),
    .rsp_valid     (rsp_valid),
    .mem_wb_valid  (mem_wb_valid),
    .mem_rd_valid  (mem_rd_valid),
    .mem_fill_valid(mem_fill_valid),
    .state         (miss_controller_i.state_q)
);

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;

    localparam int num_requests = 400;
    // a miss takes at most ten cycles, the rest is headroom
    localparam int max_cycles = num_requests * 12 + 1200;

    // one model line of the cache
    typedef struct packed {
        logic               valid;
        logic               dirty;
        dcache_pkg::tag_t   tag;
        dcache_pkg::block_t data;
    } model_line_t;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    dcache_pkg::cache_req_t req;
    logic                   rsp_valid;
    dcache_pkg::cache_rsp_t rsp;
    logic                   busy;
    logic                   mem_wb_valid;
    dcache_pkg::mem_line_t  mem_wb;
    logic                   mem_rd_valid;
    dcache_pkg::index_t     mem_rd_index;
    dcache_pkg::tag_t       mem_rd_tag;
    logic                   mem_fill_valid;
    dcache_pkg::block_t     mem_fill_data;

    // memory keyed by tag and index, cache model per set and way
    dcache_pkg::block_t mem_lines [bit [15:0]];
    model_line_t        lines [dcache_pkg::num_sets][dcache_pkg::num_ways];
    dcache_pkg::way_t   rr_way;

    int errors;
    int checks;
    int cycles = 0;

    dcache_bank dcache_bank_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // unwritten lines carry their own address in every word
    function automatic dcache_pkg::block_t mem_read(dcache_pkg::tag_t tag,
                                                    dcache_pkg::index_t index);
        dcache_pkg::block_t data;
        if (mem_lines.exists({tag, 8'(index)})) return mem_lines[{tag, 8'(index)}];
        for (int w = 0; w < dcache_pkg::words_per_block; w++) begin
            data[w*32 +: 32] = {tag, 8'(index), 8'(w), 8'hc3};
        end
        return data;
    endfunction

    function automatic dcache_pkg::block_t merge_bytes(dcache_pkg::block_t base,
                                                       dcache_pkg::block_t wdata,
                                                       dcache_pkg::byte_en_t byte_en);
        for (int b = 0; b < dcache_pkg::byte_en_width; b++) begin
            if (byte_en[b]) base[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return base;
    endfunction

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic handle_miss(input dcache_pkg::cache_req_t r);
        dcache_pkg::way_t   victim;
        model_line_t        old;
        dcache_pkg::block_t fill;
        logic               found_invalid;
        logic               wb_seen;
        logic               rd_seen;
        int                 steps;
        // lowest invalid way first, else round robin
        victim = rr_way;
        found_invalid = 1'b0;
        for (int w = dcache_pkg::num_ways - 1; w >= 0; w--) begin
            if (!lines[r.index][w].valid) begin
                victim = dcache_pkg::way_t'(w);
                found_invalid = 1'b1;
            end
        end
        if (!found_invalid) begin
            rr_way = (rr_way == dcache_pkg::num_ways - 1) ? '0 : rr_way + 1'b1;
        end
        old = lines[r.index][victim];
        wb_seen = 1'b0;
        rd_seen = 1'b0;
        steps = 0;
        // write-back, if any, comes before the read request
        while (!rd_seen && steps < 4) begin
            @(negedge clk);
            req_valid = 1'b0;
            #10;
            steps++;
            compare_value("busy", busy, 1'b1);
            if (mem_wb_valid) begin
                wb_seen = 1'b1;
                compare_value("mem_wb.index", mem_wb.index, r.index);
                compare_value("mem_wb.tag", mem_wb.tag, old.tag);
                compare_value("mem_wb.data", mem_wb.data, old.data);
                // memory keeps the victim as the model holds it
                mem_lines[{old.tag, 8'(r.index)}] = old.data;
            end
            if (mem_rd_valid) begin
                rd_seen = 1'b1;
                compare_value("mem_rd_index", mem_rd_index, r.index);
                compare_value("mem_rd_tag", mem_rd_tag, r.tag);
            end
        end
        checks += 2;
        assert (rd_seen) else begin
            errors++;
            $display("no read request followed the miss at set %0d", r.index);
        end
        assert (wb_seen == (old.valid && old.dirty)) else begin
            errors++;
            $display("victim write-back at set %0d %s", r.index,
                     wb_seen ? "was not expected" : "was missing");
        end
        fill = mem_read(r.tag, r.index);
        // memory latency of zero to five cycles
        repeat ($urandom_range(0, 5)) begin
            @(negedge clk);
            #10;
            compare_value("rsp_valid", rsp_valid, 1'b0);
            compare_value("busy", busy, 1'b1);
        end
        @(negedge clk);
        mem_fill_valid = 1'b1;
        mem_fill_data = fill;
        #10;
        compare_value("rsp_valid", rsp_valid, 1'b1);
        compare_value("rsp.hit", rsp.hit, 1'b0);
        compare_value("rsp.data", rsp.data, fill);
        @(negedge clk);
        mem_fill_valid = 1'b0;
        mem_fill_data = '0;
        #10;
        compare_value("busy", busy, 1'b0);
        lines[r.index][victim].valid = 1'b1;
        lines[r.index][victim].dirty = |r.byte_en;
        lines[r.index][victim].tag = r.tag;
        lines[r.index][victim].data = merge_bytes(fill, r.wdata, r.byte_en);
    endtask

    task automatic issue_request();
        dcache_pkg::cache_req_t r;
        dcache_pkg::way_t       way;
        logic                   hit_exp;
        r.index = dcache_pkg::index_t'($urandom_range(0, dcache_pkg::num_sets - 1));
        r.tag = dcache_pkg::tag_t'($urandom_range(0, 3));
        r.byte_en = ($urandom_range(0, 2) == 0) ? '0 : dcache_pkg::byte_en_t'($urandom);
        r.wdata = {$urandom, $urandom, $urandom, $urandom};
        hit_exp = 1'b0;
        way = '0;
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            if (!hit_exp && lines[r.index][w].valid && lines[r.index][w].tag == r.tag) begin
                hit_exp = 1'b1;
                way = dcache_pkg::way_t'(w);
            end
        end
        @(negedge clk);
        req_valid = 1'b1;
        req = r;
        #10;
        compare_value("rsp_valid", rsp_valid, hit_exp);
        if (hit_exp) begin
            // data before this request's own bytes land
            compare_value("rsp.hit", rsp.hit, 1'b1);
            compare_value("rsp.data", rsp.data, lines[r.index][way].data);
            lines[r.index][way].data = merge_bytes(lines[r.index][way].data, r.wdata, r.byte_en);
            if (|r.byte_en) lines[r.index][way].dirty = 1'b1;
        end else begin
            handle_miss(r);
        end
    endtask

    initial begin
        int assertion_failures;
        errors = 0;
        checks = 0;
        clk = 1'b0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        mem_fill_valid = 1'b0;
        mem_fill_data = '0;
        rr_way = '0;
        for (int s = 0; s < dcache_pkg::num_sets; s++) begin
            for (int w = 0; w < dcache_pkg::num_ways; w++) lines[s][w] = '0;
        end
        void'($urandom(32'h483));
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        #10;
        // quiet bank after reset
        compare_value("busy", busy, 1'b0);
        compare_value("rsp_valid", rsp_valid, 1'b0);
        compare_value("mem_wb_valid", mem_wb_valid, 1'b0);
        compare_value("mem_rd_valid", mem_rd_valid, 1'b0);
        repeat (num_requests) issue_request();
        @(negedge clk);
        req_valid = 1'b0;
        #10;
        assertion_failures = dcache_bank_i.dcache_assertions_i.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, assertion_failures);
        if (errors == 0 && assertion_failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
